/* all.f */
+incdir+common
common/sb_pkg.sv
scoreboard/sb_entry_queue.sv
scoreboard/sb_clobber_table.sv
scoreboard/sb_operand_fwd.sv
scoreboard/scoreboard.sv
test/tb_scoreboard.sv

/* Makefile */
# Verilator flow for the scoreboard, all settings can be overridden
VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_scoreboard
RTL_TOP   ?= scoreboard
SEED      ?= 27
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit code of the binary
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_scoreboard.sv */
`timescale 1ns/1ps
`include "sb_defines.svh"

module tb_scoreboard
  import sb_pkg::*;
#(
  parameter logic [15:0] SEED = 16'd27
);

  localparam int NR         = `SB_NR_ENTRIES;
  localparam int NR_REGS    = 2**`SB_REG_ADDR_BITS;
  localparam int CLK_PERIOD = 40;
  // cycles per test and the watchdog bound derived from their sum
  localparam int ISSUE_CYC  = 300;
  localparam int WBC_CYC    = 500;
  localparam int NONE_CYC   = 200;
  localparam int CLOB_CYC   = 300;
  localparam int FWD_CYC    = 400;
  localparam int FILL_CYC   = 20;
  localparam int AFTER_CYC  = 60;
  localparam int FLUSH_CYC  = FILL_CYC + 2 + AFTER_CYC;
  localparam int TOTAL_CYC  = 3 + ISSUE_CYC + WBC_CYC + NONE_CYC + CLOB_CYC + FWD_CYC + FLUSH_CYC;
  localparam int TIMEOUT_NS = (TOTAL_CYC + 100) * CLK_PERIOD;

  // per-cycle chances in sixteenths
  // rd_mask narrows rd and rs to force hits
  typedef struct packed {
    logic [3:0] valid, ack, branch, flush_unissued, wb, ex, commit, none;
    reg_addr_t  rd_mask;
  } knobs_t;

  //                          valid  ack    branch fl_un  wb     ex     commit none   rd_mask
  localparam knobs_t ISSUE_K = '{4'd12, 4'd10, 4'd4,  4'd3,  4'd6,  4'd0,  4'd4,  4'd2,  5'h1f};
  localparam knobs_t WBC_K   = '{4'd10, 4'd12, 4'd0,  4'd0,  4'd12, 4'd4,  4'd10, 4'd0,  5'h1f};
  localparam knobs_t NONE_K  = '{4'd10, 4'd12, 4'd0,  4'd0,  4'd4,  4'd0,  4'd6,  4'd15, 5'h1f};
  localparam knobs_t CLOB_K  = '{4'd12, 4'd12, 4'd2,  4'd1,  4'd6,  4'd2,  4'd5,  4'd3,  5'h07};
  localparam knobs_t FWD_K   = '{4'd12, 4'd12, 4'd0,  4'd0,  4'd10, 4'd5,  4'd6,  4'd3,  5'h03};
  localparam knobs_t FILL_K  = '{4'd14, 4'd14, 4'd0,  4'd0,  4'd4,  4'd0,  4'd0,  4'd2,  5'h1f};

  logic      clk_i, rst_ni, flush_i, flush_unissued_i, unresolved_branch_i;
  sb_entry_t decoded_instr_i, issue_instr_o, commit_instr_o;
  logic      decoded_valid_i, decoded_ack_o, issue_valid_o, issue_ack_i;
  logic      commit_ack_i, sb_full_o;
  wb_t       wb_i;
  fu_t [NR_REGS-1:0] rd_clobber_o;
  reg_addr_t rs1_i, rs2_i;
  xlen_t     rs1_o, rs2_o;
  logic      rs1_valid_o, rs2_valid_o;

  // reference model state mirroring the current slots
  sb_slot_t [NR-1:0] m_slots;
  trans_id_t m_iptr, m_cptr;
  int        m_cnt;
  logic      took_last;
  logic [15:0] lfsr;
  int        err_cnt, chk_cnt, test_cnt;

  scoreboard scoreboard_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // random source with taps x^16 + x^14 + x^13 + x^11 + 1
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic chance(input logic [3:0] p);
    return 4'(lfsr_bits(4)) < p;
  endfunction

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  task automatic model_update();
    sb_slot_t [NR-1:0] nxt;
    sb_entry_t ent;
    logic take;
    take      = decoded_valid_i && issue_ack_i && (m_cnt != NR - 1) && !flush_unissued_i;
    took_last = take && !flush_i;
    if (flush_i) begin
      m_slots = '0;
      m_iptr  = '0;
      m_cptr  = '0;
      m_cnt   = 0;
    end else begin
      nxt = m_slots;
      if (take) begin
        ent          = decoded_instr_i;
        ent.trans_id = m_iptr;
        ent.valid    = 1'b0;
        nxt[m_iptr].issued = 1'b1;
        nxt[m_iptr].entry  = ent;
      end
      // entries without a unit finish on their own
      for (int i = 0; i < NR; i++) begin
        if (m_slots[i].issued && m_slots[i].entry.fu == NONE) nxt[i].entry.valid = 1'b1;
      end
      if (wb_i.valid && m_slots[wb_i.trans_id].issued) begin
        nxt[wb_i.trans_id].entry.valid  = 1'b1;
        nxt[wb_i.trans_id].entry.result = wb_i.data;
        if (wb_i.ex_valid) begin
          nxt[wb_i.trans_id].entry.ex_valid = 1'b1;
          nxt[wb_i.trans_id].entry.ex_cause = wb_i.ex_cause;
        end
      end
      if (commit_ack_i) begin
        nxt[m_cptr].issued      = 1'b0;
        nxt[m_cptr].entry.valid = 1'b0;
      end
      m_slots = nxt;
      m_iptr  = m_iptr + trans_id_t'(take);
      m_cptr  = m_cptr + trans_id_t'(commit_ack_i);
      m_cnt   = m_cnt + int'(take) - int'(commit_ack_i);
    end
  endtask

  // lowest issued writer of r
  // x0 is never pending
  function automatic fu_t expected_clobber(input int r);
    fu_t  res;
    logic found;
    res   = NONE;
    found = 1'b0;
    for (int i = 0; i < NR; i++) begin
      if (r != 0 && !found && m_slots[i].issued && m_slots[i].entry.rd == reg_addr_t'(r)) begin
        res   = m_slots[i].entry.fu;
        found = 1'b1;
      end
    end
    return res;
  endfunction

  // live beat first and then the lowest finished slot
  function automatic operand_t expected_operand(input reg_addr_t rs);
    operand_t res;
    res = '0;
    if (wb_i.valid && !wb_i.ex_valid && m_slots[wb_i.trans_id].entry.rd == rs) begin
      res = '{1'b1, wb_i.data};
    end else begin
      for (int i = 0; i < NR; i++) begin
        if (!res.valid && m_slots[i].issued && m_slots[i].entry.valid
            && m_slots[i].entry.rd == rs) res = '{1'b1, m_slots[i].entry.result};
      end
    end
    if (rs == '0) res.valid = 1'b0;
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus and checks
  // ----------------------------------------------------------------------

  task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("ERROR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_outputs();
    logic      full;
    sb_entry_t exp_entry;
    operand_t  op1, op2;
    full      = (m_cnt == NR - 1);
    exp_entry = decoded_instr_i;
    exp_entry.trans_id = m_iptr;
    expect_eq("sb_full_o", 64'(sb_full_o), 64'(full));
    expect_eq("decoded_ack_o", 64'(decoded_ack_o), 64'(issue_ack_i & ~full));
    expect_eq("issue_valid_o", 64'(issue_valid_o),
              64'(decoded_valid_i & ~unresolved_branch_i & ~full));
    expect_eq("issue_instr_o", 64'(issue_instr_o), 64'(exp_entry));
    exp_entry = m_slots[m_cptr].entry;
    exp_entry.trans_id = m_cptr;
    expect_eq("commit valid", 64'(commit_instr_o.valid), 64'(exp_entry.valid));
    if (exp_entry.valid) expect_eq("commit_instr_o", 64'(commit_instr_o), 64'(exp_entry));
    for (int r = 0; r < NR_REGS; r++) begin
      expect_eq($sformatf("rd_clobber_o[%0d]", r), 64'(rd_clobber_o[r]), 64'(expected_clobber(r)));
    end
    op1 = expected_operand(rs1_i);
    op2 = expected_operand(rs2_i);
    expect_eq("rs1_valid_o", 64'(rs1_valid_o), 64'(op1.valid));
    expect_eq("rs2_valid_o", 64'(rs2_valid_o), 64'(op2.valid));
    if (op1.valid) expect_eq("rs1_o", 64'(rs1_o), 64'(op1.data));
    if (op2.valid) expect_eq("rs2_o", 64'(rs2_o), 64'(op2.data));
  endtask

  task automatic advance();
    @(posedge clk_i);
    model_update();
    #2;
  endtask

  task automatic drive_inputs(input knobs_t k);
    int        start;
    trans_id_t idx;
    logic      found;
    // decoder keeps a refused instruction on its outputs
    if (!(decoded_valid_i && !took_last)) begin
      decoded_valid_i = chance(k.valid);
      decoded_instr_i = '0;
      if (chance(k.none)) decoded_instr_i.fu = NONE;
      else decoded_instr_i.fu = fu_t'(3'(lfsr_bits(3) % 32'd6) + 3'd1);
      decoded_instr_i.rd = reg_addr_t'(lfsr_bits(5)) & k.rd_mask;
    end
    issue_ack_i         = chance(k.ack);
    unresolved_branch_i = chance(k.branch);
    flush_unissued_i    = chance(k.flush_unissued);
    flush_i             = 1'b0;
    wb_i                = '0;
    // beats only target issued slots searched from a random start
    if (m_cnt > 0 && chance(k.wb)) begin
      start = int'(lfsr_bits(3));
      found = 1'b0;
      for (int j = 0; j < NR; j++) begin
        idx = trans_id_t'(start + j);
        if (!found && m_slots[idx].issued) begin
          found         = 1'b1;
          wb_i.trans_id = idx;
        end
      end
      wb_i.valid    = found;
      wb_i.data     = xlen_t'(lfsr_bits(32));
      wb_i.ex_valid = chance(k.ex);
      if (wb_i.ex_valid) wb_i.ex_cause = cause_t'(lfsr_bits(4));
    end
    commit_ack_i = m_slots[m_cptr].entry.valid && chance(k.commit);
    rs1_i = reg_addr_t'(lfsr_bits(5)) & k.rd_mask;
    rs2_i = reg_addr_t'(lfsr_bits(5)) & k.rd_mask;
  endtask

  task automatic run_random(input int n, input knobs_t k);
    repeat (n) begin
      advance();
      drive_inputs(k);
      #20;
      check_outputs();
    end
  endtask

  task automatic report_test(input string name, input int cycles, input int errs_before);
    test_cnt++;
    $display("test %-10s %4d cycles, %0d errors", name, cycles, err_cnt - errs_before);
  endtask

  task automatic run_test(input string name, input int n, input knobs_t k);
    int errs;
    errs = err_cnt;
    run_random(n, k);
    report_test(name, n, errs);
  endtask

  // one flush cycle and then a fresh instruction offered at slot zero
  task automatic flush_all();
    advance();
    drive_inputs(FILL_K);
    flush_i = 1'b1;
    #20;
    check_outputs();
    advance();
    flush_i            = 1'b0;
    flush_unissued_i   = 1'b0;
    decoded_valid_i    = 1'b1;
    decoded_instr_i    = '0;
    decoded_instr_i.fu = ALU;
    issue_ack_i        = 1'b1;
    commit_ack_i       = 1'b0;
    wb_i               = '0;
    #20;
    check_outputs();
    expect_eq("sb_full_o after flush", 64'(sb_full_o), 64'd0);
    expect_eq("commit valid after flush", 64'(commit_instr_o.valid), 64'd0);
    expect_eq("trans_id after flush", 64'(issue_instr_o.trans_id), 64'd0);
    for (int r = 0; r < NR_REGS; r++) begin
      expect_eq("rd_clobber_o after flush", 64'(rd_clobber_o[r]), 64'(NONE));
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    int errs;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    flush_unissued_i = 1'b0;
    unresolved_branch_i = 1'b0;
    decoded_instr_i = '0;
    decoded_valid_i = 1'b0;
    issue_ack_i = 1'b0;
    wb_i = '0;
    commit_ack_i = 1'b0;
    rs1_i = '0;
    rs2_i = '0;
    lfsr = SEED;
    m_slots = '0;
    m_iptr = '0;
    m_cptr = '0;
    m_cnt = 0;
    took_last = 1'b0;
    err_cnt = 0;
    chk_cnt = 0;
    test_cnt = 0;
    repeat (2) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    #20 check_outputs();
    report_test("reset", 1, 0);
    run_test("issue", ISSUE_CYC, ISSUE_K);
    run_test("commit", WBC_CYC, WBC_K);
    run_test("fu_none", NONE_CYC, NONE_K);
    run_test("clobber", CLOB_CYC, CLOB_K);
    run_test("forward", FWD_CYC, FWD_K);
    errs = err_cnt;
    run_random(FILL_CYC, FILL_K);
    flush_all();
    run_random(AFTER_CYC, CLOB_K);
    report_test("flush", FLUSH_CYC, errs);
    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

endmodule

/* scoreboard/scoreboard.sv */
`timescale 1ns/1ps
`include "sb_defines.svh"

module scoreboard
  import sb_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // flush controls
  input  logic                                 flush_i,
  input  logic                                 flush_unissued_i,
  input  logic                                 unresolved_branch_i,
  // decoder side
  input  sb_entry_t                            decoded_instr_i,
  input  logic                                 decoded_valid_i,
  output logic                                 decoded_ack_o,
  // issue side
  output sb_entry_t                            issue_instr_o,
  output logic                                 issue_valid_o,
  input  logic                                 issue_ack_i,
  // write-back port
  input  wb_t                                  wb_i,
  // commit port
  output sb_entry_t                            commit_instr_o,
  input  logic                                 commit_ack_i,
  output logic                                 sb_full_o,
  // pending writer per integer register
  output fu_t [2**`SB_REG_ADDR_BITS-1:0]       rd_clobber_o,
  // operand reads
  input  reg_addr_t                            rs1_i,
  input  reg_addr_t                            rs2_i,
  output xlen_t                                rs1_o,
  output xlen_t                                rs2_o,
  output logic                                 rs1_valid_o,
  output logic                                 rs2_valid_o
);

  // slot array, owned by the queue and read by the lookups
  sb_slot_t [`SB_NR_ENTRIES-1:0] slots;

  sb_entry_queue entry_queue_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .flush_unissued_i    (flush_unissued_i),
    .unresolved_branch_i (unresolved_branch_i),
    .decoded_instr_i     (decoded_instr_i),
    .decoded_valid_i     (decoded_valid_i),
    .decoded_ack_o       (decoded_ack_o),
    .issue_instr_o       (issue_instr_o),
    .issue_valid_o       (issue_valid_o),
    .issue_ack_i         (issue_ack_i),
    .wb_i                (wb_i),
    .commit_instr_o      (commit_instr_o),
    .commit_ack_i        (commit_ack_i),
    .sb_full_o           (sb_full_o),
    .slots_o             (slots)
  );

  sb_clobber_table clobber_table_inst (
    .slots_i      (slots),
    .rd_clobber_o (rd_clobber_o)
  );

  // forwarding also sees the live write-back beat
  sb_operand_fwd operand_fwd_inst (
    .slots_i     (slots),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

/* scoreboard/sb_operand_fwd.sv */
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_operand_fwd
  import sb_pkg::*;
(
  input  sb_slot_t [`SB_NR_ENTRIES-1:0]  slots_i,
  input  wb_t                            wb_i,
  input  reg_addr_t                      rs1_i,
  input  reg_addr_t                      rs2_i,
  output xlen_t                          rs1_o,
  output xlen_t                          rs2_o,
  output logic                           rs1_valid_o,
  output logic                           rs2_valid_o
);

  localparam int unsigned NR_ENTRIES = `SB_NR_ENTRIES;

  operand_t rs1_fwd;
  operand_t rs2_fwd;

  // ----------------------------------------------------------------------
  // lookup shared by both read ports
  // ----------------------------------------------------------------------

  function automatic operand_t fwd_lookup(
    input sb_slot_t [NR_ENTRIES-1:0] slots,
    input wb_t                       wb,
    input reg_addr_t                 rs
  );
    operand_t res;
    res = '0;
    // finished entries, lowest index has priority
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (slots[i].issued && slots[i].entry.valid && slots[i].entry.rd == rs) begin
        res.valid = 1'b1;
        res.data  = slots[i].entry.result;
      end
    end
    // live write-back beat overrides stored results
    // a faulting beat carries no usable data
    if (wb.valid && !wb.ex_valid && slots[wb.trans_id].entry.rd == rs) begin
      res.valid = 1'b1;
      res.data  = wb.data;
    end
    // x0 reads come from the register file
    if (rs == '0) begin
      res.valid = 1'b0;
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // read ports
  // ----------------------------------------------------------------------

  always_comb begin
    rs1_fwd = fwd_lookup(slots_i, wb_i, rs1_i);
    rs2_fwd = fwd_lookup(slots_i, wb_i, rs2_i);
  end

  assign rs1_o       = rs1_fwd.data;
  assign rs1_valid_o = rs1_fwd.valid;
  assign rs2_o       = rs2_fwd.data;
  assign rs2_valid_o = rs2_fwd.valid;

endmodule

/* scoreboard/sb_clobber_table.sv */
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_clobber_table
  import sb_pkg::*;
(
  input  sb_slot_t [`SB_NR_ENTRIES-1:0]     slots_i,
  output fu_t [2**`SB_REG_ADDR_BITS-1:0]    rd_clobber_o
);

  localparam int unsigned NR_ENTRIES = `SB_NR_ENTRIES;
  localparam int unsigned NR_REGS    = 2**`SB_REG_ADDR_BITS;

  // one bit per register and slot, set where an issued slot writes it
  logic [NR_REGS-1:0][NR_ENTRIES-1:0] writer;

  // ----------------------------------------------------------------------
  // decode destination registers
  // ----------------------------------------------------------------------

  always_comb begin
    writer = '0;
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      writer[slots_i[i].entry.rd][i] = slots_i[i].issued;
    end
    // x0 is hardwired, never pending
    writer[0] = '0;
  end

  // ----------------------------------------------------------------------
  // fixed priority select, lowest slot index wins
  // ----------------------------------------------------------------------

  always_comb begin
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      rd_clobber_o[r] = NONE;
      // walk downwards so the lowest matching slot is written last
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (writer[r][i]) begin
          rd_clobber_o[r] = slots_i[i].entry.fu;
        end
      end
    end
  end

endmodule

/* scoreboard/sb_entry_queue.sv */
`timescale 1ns/1ps
`include "sb_defines.svh"

module sb_entry_queue
  import sb_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           flush_unissued_i,
  input  logic                           unresolved_branch_i,
  input  sb_entry_t                      decoded_instr_i,
  input  logic                           decoded_valid_i,
  output logic                           decoded_ack_o,
  output sb_entry_t                      issue_instr_o,
  output logic                           issue_valid_o,
  input  logic                           issue_ack_i,
  input  wb_t                            wb_i,
  output sb_entry_t                      commit_instr_o,
  input  logic                           commit_ack_i,
  output logic                           sb_full_o,
  output sb_slot_t [`SB_NR_ENTRIES-1:0]  slots_o
);

  localparam int unsigned NR_ENTRIES = `SB_NR_ENTRIES;

  sb_slot_t [NR_ENTRIES-1:0] slots_q, slots_n;

  // issue pointer is the next free slot, commit pointer the oldest one
  trans_id_t issue_ptr_q, issue_ptr_n;
  trans_id_t commit_ptr_q, commit_ptr_n;

  // occupancy, same width as the index so it saturates at depth minus one
  logic [$bits(trans_id_t)-1:0] cnt_q, cnt_n;

  logic full;
  logic issue_en;

  // all ones in the count means no room for another entry
  assign full      = &cnt_q;
  assign sb_full_o = full;
  assign slots_o   = slots_q;

  // ----------------------------------------------------------------------
  // issue and commit views
  // ----------------------------------------------------------------------

  always_comb begin
    // pass the decoded instruction through, tagged with its slot
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr_q;
    // hold off issue behind an unresolved branch
    issue_valid_o          = decoded_valid_i & ~unresolved_branch_i & ~full;
    decoded_ack_o          = issue_ack_i & ~full;
  end

  always_comb begin
    // oldest slot goes straight to commit
    commit_instr_o          = slots_q[commit_ptr_q].entry;
    commit_instr_o.trans_id = commit_ptr_q;
  end

  // nothing enters while unissued work is being dropped
  assign issue_en = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  // ----------------------------------------------------------------------
  // slot updates
  // ----------------------------------------------------------------------

  always_comb begin
    slots_n = slots_q;

    // new entry at the issue pointer, no result yet
    if (issue_en) begin
      slots_n[issue_ptr_q].issued      = 1'b1;
      slots_n[issue_ptr_q].entry       = issue_instr_o;
      slots_n[issue_ptr_q].entry.valid = 1'b0;
    end

    // unit-less instructions are done one cycle after issue
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (slots_q[i].issued && slots_q[i].entry.fu == NONE) begin
        slots_n[i].entry.valid = 1'b1;
      end
    end

    // write-back, stale beats to empty slots are dropped
    if (wb_i.valid && slots_q[wb_i.trans_id].issued) begin
      slots_n[wb_i.trans_id].entry.valid  = 1'b1;
      slots_n[wb_i.trans_id].entry.result = wb_i.data;
      // keep any earlier exception unless a new one arrives
      if (wb_i.ex_valid) begin
        slots_n[wb_i.trans_id].entry.ex_valid = 1'b1;
        slots_n[wb_i.trans_id].entry.ex_cause = wb_i.ex_cause;
      end
    end

    // retire the oldest slot
    if (commit_ack_i) begin
      slots_n[commit_ptr_q].issued      = 1'b0;
      slots_n[commit_ptr_q].entry.valid = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------------------

  // wrap by overflow, depth is a power of two
  assign issue_ptr_n  = issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_n = commit_ptr_q + trans_id_t'(commit_ack_i);
  assign cnt_n        = cnt_q + trans_id_t'(issue_en) - trans_id_t'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slots_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // full flush empties every slot
      slots_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      slots_q      <= slots_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

endmodule

/* common/sb_pkg.sv */
`include "sb_defines.svh"

package sb_pkg;

  // queue index, doubles as the transaction id handed out at issue
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;

  // integer register address
  typedef logic [`SB_REG_ADDR_BITS-1:0] reg_addr_t;

  // result word
  typedef logic [`SB_XLEN-1:0] xlen_t;

  // exception cause
  typedef logic [`SB_CAUSE_BITS-1:0] cause_t;

  // functional unit that executes an instruction
  // NONE means the instruction finishes without any unit
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5,
    CSR    = 3'd6
  } fu_t;

  // one decoded instruction as it moves through the scoreboard
  // valid is set once the result is in
  typedef struct packed {
    trans_id_t trans_id;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      valid;
    logic      ex_valid;
    cause_t    ex_cause;
  } sb_entry_t;

  // single write-back beat from the functional units
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
    cause_t    ex_cause;
  } wb_t;

  // stored queue slot, issued marks an occupied slot
  typedef struct packed {
    logic      issued;
    sb_entry_t entry;
  } sb_slot_t;

  // result of one source operand lookup
  typedef struct packed {
    logic  valid;
    xlen_t data;
  } operand_t;

endpackage

/* common/sb_defines.svh */
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// ----------------------------------------------------------------------
// scoreboard sizing
// ----------------------------------------------------------------------

// number of in-flight instructions tracked by the queue
// must stay a power of two, pointers wrap by plain overflow
`define SB_NR_ENTRIES 8

// width of a result word written back by a functional unit
`define SB_XLEN 32

// integer register address width, 32 architectural registers
`define SB_REG_ADDR_BITS 5

// exception cause code width
`define SB_CAUSE_BITS 4

`endif
